//--- vlog.f
+incdir+logic
logic/dual_issue_pkg.sv
logic/fetch_queue.sv
logic/inst_decoder.sv
logic/issue_ctrl.sv
logic/regfile.sv
logic/forward_unit.sv
logic/lane_alu.sv
logic/dual_issue_core.sv
bench/tb_dual_issue_core.sv

//--- Bender.yml
package:
  name: dual_issue_core

sources:
  - include_dirs:
      - logic
    files:
      - logic/dual_issue_pkg.sv
      - logic/fetch_queue.sv
      - logic/inst_decoder.sv
      - logic/issue_ctrl.sv
      - logic/regfile.sv
      - logic/forward_unit.sv
      - logic/lane_alu.sv
      - logic/dual_issue_core.sv
  - target: test
    include_dirs:
      - logic
    files:
      - bench/tb_dual_issue_core.sv

//--- bench/tb_dual_issue_core.sv
`timescale 1ns/1ps
`include "dual_issue_macros.svh"

module tb_dual_issue_core import dual_issue_pkg::*; ();

    localparam int CLK_HALF       = 4;
    localparam int GAP_PAIR       = 14;
    localparam int GAP_CYCLES     = 16;
    localparam int COMMIT_TIMEOUT = 400;
    localparam int DRAIN_CYCLES   = 12;

    // destination 0 marks a word that commits nothing
    typedef struct packed {
        logic [2:0]         grp;
        logic [`XLEN-1:0]   inst;
        logic [`REG_AW-1:0] waddr;
        logic [`XLEN-1:0]   wdata;
    } row_t;

    logic             clk;
    logic             rst_n_i;
    fetch_resp_t      fetch_resp_i;
    logic             fetch_req_o;
    logic [`XLEN-1:0] fetch_pc_o;
    commit_t          commit_master_o;
    commit_t          commit_slave_o;

    row_t  rows[$];
    int    write_rows[$];
    int    wr_pos;
    int    last_write[1:6];
    int    group_err[1:6];
    bit    group_done[1:6];
    int    errors;
    int    accepted;
    int    withheld;
    int    req_low;
    string names[1:6] = '{"reset state", "independent ops", "adjacent dependent pairs",
                          "forwarding distances", "fetch gaps and back-pressure",
                          "nops and register 0"};

    dual_issue_core u_dut (
        .clk(clk), .rst_n_i(rst_n_i), .fetch_resp_i(fetch_resp_i),
        .fetch_req_o(fetch_req_o), .fetch_pc_o(fetch_pc_o),
        .commit_master_o(commit_master_o), .commit_slave_o(commit_slave_o)
    );

    always #(CLK_HALF) clk = ~clk;

    function automatic logic [`XLEN-1:0] r_type(input int rs, input int rt, input int rd,
                                                input int sa, input logic [5:0] fn);
        return {`OP_SPECIAL, 5'(rs), 5'(rt), 5'(rd), 5'(sa), fn};
    endfunction

    function automatic logic [`XLEN-1:0] i_type(input logic [5:0] op, input int rs,
                                                input int rt, input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    task automatic add_row(input int grp, input logic [`XLEN-1:0] inst, input int waddr,
                           input logic [`XLEN-1:0] wdata);
        rows.push_back('{grp: 3'(grp), inst: inst, waddr: 5'(waddr), wdata: wdata});
    endtask

    // past the program end the fetch port returns nops
    function automatic logic [`XLEN-1:0] word_at(input int idx);
        if (idx < rows.size()) begin
            return rows[idx].inst;
        end
        return '0;
    endfunction

    task automatic count_error(input int grp);
        errors++;
        group_err[grp]++;
    endtask

    task automatic check_commit(input commit_t got, input commit_t exp, input int grp);
        if (got !== exp) begin
            $display("Error at %0t: commit v%b pc %h r%0d=%h, expected v%b pc %h r%0d=%h",
                     $time, got.valid, got.pc, got.waddr, got.wdata,
                     exp.valid, exp.pc, exp.waddr, exp.wdata);
            count_error(grp);
        end
    endtask

    task automatic check_pc(input string what, input logic [`XLEN-1:0] got,
                            input logic [`XLEN-1:0] exp, input int grp);
        if (got !== exp) begin
            $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
            count_error(grp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp,
                              input int grp);
        if (got !== exp) begin
            $display("Error at %0t: %s is %b, expected %b", $time, what, got, exp);
            count_error(grp);
        end
    endtask

    task automatic build_table();
        // independent ops of every kind seeded from $0
        add_row(2, i_type(`OP_LUI, 0, 1, 16'h1234), 1, 32'h1234_0000);
        add_row(2, i_type(`OP_ORI, 0, 2, 16'h00F0), 2, 32'h0000_00F0);
        add_row(2, i_type(`OP_ADDIU, 0, 3, 16'hFFFD), 3, 32'hFFFF_FFFD);
        add_row(2, i_type(`OP_ORI, 0, 4, 16'h5A5A), 4, 32'h0000_5A5A);
        add_row(2, r_type(1, 2, 5, 0, `FN_ADDU), 5, 32'h1234_00F0);
        add_row(2, r_type(4, 2, 6, 0, `FN_SUBU), 6, 32'h0000_596A);
        add_row(2, r_type(1, 3, 7, 0, `FN_AND), 7, 32'h1234_0000);
        add_row(2, r_type(2, 4, 8, 0, `FN_OR), 8, 32'h0000_5AFA);
        add_row(2, r_type(4, 2, 9, 0, `FN_XOR), 9, 32'h0000_5AAA);
        add_row(2, r_type(3, 2, 10, 0, `FN_SLT), 10, 32'h0000_0001);
        add_row(2, r_type(0, 2, 11, 4, `FN_SLL), 11, 32'h0000_0F00);
        add_row(2, r_type(2, 3, 12, 0, `FN_SLT), 12, 32'h0000_0000);
        // serial chain that issues one per cycle and backs up the FIFO
        add_row(3, i_type(`OP_ADDIU, 5, 13, 16'h0010), 13, 32'h1234_0100);
        add_row(3, r_type(13, 13, 14, 0, `FN_ADDU), 14, 32'h2468_0200);
        add_row(3, r_type(14, 1, 15, 0, `FN_SUBU), 15, 32'h1234_0200);
        add_row(3, r_type(15, 14, 16, 0, `FN_XOR), 16, 32'h365C_0000);
        add_row(3, r_type(0, 16, 16, 1, `FN_SLL), 16, 32'h6CB8_0000);
        add_row(3, i_type(`OP_ADDIU, 16, 16, 16'h7FFF), 16, 32'h6CB8_7FFF);
        add_row(3, r_type(16, 0, 13, 0, `FN_SLT), 13, 32'h0000_0000);
        add_row(3, i_type(`OP_ORI, 13, 13, 16'h00AA), 13, 32'h0000_00AA);
        add_row(4, i_type(`OP_ADDIU, 0, 17, 16'h0007), 17, 32'h0000_0007);
        add_row(4, r_type(0, 17, 18, 2, `FN_SLL), 18, 32'h0000_001C);
        add_row(4, r_type(17, 17, 19, 0, `FN_ADDU), 19, 32'h0000_000E);
        add_row(4, r_type(17, 18, 20, 0, `FN_SUBU), 20, 32'hFFFF_FFEB);
        add_row(4, r_type(20, 19, 21, 0, `FN_XOR), 21, 32'hFFFF_FFE5);
        // same destination twice, then a read of it
        add_row(4, i_type(`OP_ADDIU, 0, 25, 16'h0011), 25, 32'h0000_0011);
        add_row(4, i_type(`OP_ADDIU, 0, 25, 16'h0022), 25, 32'h0000_0022);
        add_row(4, r_type(25, 21, 26, 0, `FN_ADDU), 26, 32'h0000_0007);
        add_row(4, r_type(20, 26, 27, 0, `FN_SLT), 27, 32'h0000_0001);
        add_row(5, i_type(`OP_LUI, 0, 28, 16'hBEEF), 28, 32'hBEEF_0000);
        add_row(5, i_type(`OP_ORI, 28, 28, 16'hCAFE), 28, 32'hBEEF_CAFE);
        add_row(5, r_type(28, 1, 29, 0, `FN_SUBU), 29, 32'hACBB_CAFE);
        add_row(6, 32'h0000_0000, 0, '0);
        add_row(6, i_type(`OP_ADDIU, 1, 0, 16'h0055), 0, '0);
        add_row(6, r_type(1, 2, 0, 0, `FN_ADDU), 0, '0);
        add_row(6, 32'hFC00_0000, 0, '0);
        add_row(6, r_type(0, 0, 30, 0, `FN_OR), 30, 32'h0000_0000);
        add_row(6, r_type(0, 3, 31, 0, `FN_ADDU), 31, 32'hFFFF_FFFD);
        foreach (rows[i]) begin
            if (rows[i].waddr != '0) begin
                write_rows.push_back(i);
                last_write[rows[i].grp] = i;
            end
        end
    endtask

    task automatic retire(input commit_t got);
        int      idx;
        int      grp;
        commit_t exp;
        if (wr_pos >= write_rows.size()) begin
            $display("Error at %0t: unexpected commit from pc %h", $time, got.pc);
            count_error(6);
            return;
        end
        idx = write_rows[wr_pos];
        grp = rows[idx].grp;
        exp = '{valid: 1'b1, pc: `RESET_PC + 32'(idx * 4), waddr: rows[idx].waddr,
                wdata: rows[idx].wdata};
        check_commit(got, exp, grp);
        wr_pos++;
        if (idx == last_write[grp] && grp != 5) begin
            group_done[grp] = 1'b1;
            $display("behavior %0d (%s) finished with %0d errors", grp, names[grp],
                     group_err[grp]);
        end
    endtask

    always @(negedge clk) begin : commit_monitor
        int prev;
        if (rst_n_i) begin
            if (commit_master_o.valid && commit_slave_o.valid) begin
                check_pc("slave commit pc", commit_slave_o.pc, commit_master_o.pc + 32'd4, 2);
            end
            if (commit_slave_o.valid && !commit_master_o.valid) begin
                // legal only when the master slot held a word that writes nothing
                prev = int'((commit_slave_o.pc - `RESET_PC) >> 2) - 1;
                if (prev < 0 || (prev < rows.size() && rows[prev].waddr != '0)) begin
                    $display("slave lane committed pc %h while its master retired nothing",
                             commit_slave_o.pc);
                    count_error(3);
                end
            end
            if (commit_master_o.valid) begin
                retire(commit_master_o);
            end
            if (commit_slave_o.valid) begin
                retire(commit_slave_o);
            end
        end
    end

    initial begin : fetch_responder
        int               pair;
        bit               give;
        int               gap_left;
        logic [`XLEN-1:0] exp_pc;
        void'($urandom(44));
        gap_left     = GAP_CYCLES;
        exp_pc       = `RESET_PC;
        fetch_resp_i = '0;
        forever begin
            @(negedge clk);
            if (rst_n_i) begin
                check_pc("fetch_pc_o", fetch_pc_o, exp_pc, 5);
                pair   = int'((fetch_pc_o - `RESET_PC) >> 3);
                // full rate first, then one long silence, then random gaps
                if (pair < GAP_PAIR) begin
                    give = 1'b1;
                end else if (gap_left > 0) begin
                    give = 1'b0;
                    gap_left--;
                end else begin
                    give = ($urandom % 4) != 0;
                end
                if (!give) begin
                    withheld++;
                end
                if (!fetch_req_o) begin
                    req_low++;
                end
                if (give && fetch_req_o) begin
                    accepted++;
                    exp_pc = exp_pc + 32'd8;
                end
                fetch_resp_i = '{valid: give, word0: word_at(2 * pair),
                                 word1: word_at(2 * pair + 1)};
            end else begin
                fetch_resp_i = '0;
            end
        end
    end

    initial begin : main_sequence
        int cyc;
        int g;
        int failed;
        bit timed_out;
        clk     = 1'b0;
        rst_n_i = 1'b0;
        build_table();
        for (cyc = 0; cyc <= 5; cyc++) begin
            @(negedge clk);
            check_flag("commit_master_o.valid", commit_master_o.valid, 1'b0, 1);
            check_flag("commit_slave_o.valid", commit_slave_o.valid, 1'b0, 1);
            check_flag("fetch_req_o", fetch_req_o, 1'b1, 1);
            check_pc("fetch_pc_o after reset", fetch_pc_o, `RESET_PC, 1);
            if (cyc == 4) begin
                rst_n_i <= 1'b1;
            end
        end
        group_done[1] = 1'b1;
        $display("behavior 1 (%s) finished with %0d errors", names[1], group_err[1]);
        timed_out = 1'b0;
        cyc = 0;
        while (wr_pos < write_rows.size() && cyc < COMMIT_TIMEOUT) begin
            @(negedge clk);
            cyc++;
        end
        if (wr_pos < write_rows.size()) begin
            $display("Timeout: row %0d never committed within %0d cycles",
                     write_rows[wr_pos], COMMIT_TIMEOUT);
            timed_out = 1'b1;
        end
        // nops past the program end must stay silent
        for (cyc = 0; cyc < DRAIN_CYCLES; cyc++) begin
            @(negedge clk);
        end
        if (req_low == 0) begin
            $display("fetch_req_o never dropped, so the FIFO never filled");
            count_error(5);
        end
        if (withheld == 0) begin
            $display("no fetch response was ever withheld");
            count_error(5);
        end
        group_done[5] = !timed_out;
        $display("behavior 5 (%s) finished: %0d pairs, %0d gaps, %0d stalls, %0d errors",
                 names[5], accepted, withheld, req_low, group_err[5]);
        failed = 0;
        for (g = 1; g <= 6; g++) begin
            if (group_err[g] != 0 || !group_done[g]) begin
                failed++;
            end
        end
        $display("summary: 6 behaviors, %0d passed, %0d failed, %0d errors",
                 6 - failed, failed, errors);
        if (failed == 0 && !timed_out) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- logic/dual_issue_core.sv
`timescale 1ns/1ps
`include "dual_issue_macros.svh"

module dual_issue_core import dual_issue_pkg::*; (
    input  logic             clk,
    input  logic             rst_n_i,
    input  fetch_resp_t      fetch_resp_i,
    output logic             fetch_req_o,
    output logic [`XLEN-1:0] fetch_pc_o,
    output commit_t          commit_master_o,
    output commit_t          commit_slave_o
);

    localparam int CNT_W = $clog2(`IQ_DEPTH) + 1;

    iq_entry_t        head0, head1;
    logic [CNT_W-1:0] iq_count;
    logic [1:0]       pop_count;
    decoded_t         dec_m, dec_s;
    logic [`XLEN-1:0] rf_m_rs, rf_m_rt, rf_s_rs, rf_s_rt;
    logic [`XLEN-1:0] op_m_rs, op_m_rt, op_s_rs, op_s_rt;
    exec_slot_t       e_master_d, e_slave_d, e_master_q, e_slave_q;
    result_t          e_master_res, e_slave_res;
    result_t          m_master_q, m_slave_q, w_master_q, w_slave_q;

    fetch_queue #(.DEPTH(`IQ_DEPTH)) u_fetch_queue (
        .clk(clk), .rst_n_i(rst_n_i), .fetch_resp_i(fetch_resp_i), .pop_count_i(pop_count),
        .fetch_req_o(fetch_req_o), .fetch_pc_o(fetch_pc_o),
        .head0_o(head0), .head1_o(head1), .count_o(iq_count)
    );

    inst_decoder u_dec_master (.inst_i(head0.inst), .dec_o(dec_m));
    inst_decoder u_dec_slave  (.inst_i(head1.inst), .dec_o(dec_s));

    issue_ctrl #(.CNT_W(CNT_W)) u_issue_ctrl (
        .count_i(iq_count), .master_dec_i(dec_m), .slave_dec_i(dec_s),
        .pop_count_o(pop_count)
    );

    regfile u_regfile (
        .clk(clk), .rst_n_i(rst_n_i),
        .raddr_0_i(dec_m.rs), .raddr_1_i(dec_m.rt), .raddr_2_i(dec_s.rs), .raddr_3_i(dec_s.rt),
        .wr_master_i(w_master_q), .wr_slave_i(w_slave_q),
        .rdata_0_o(rf_m_rs), .rdata_1_o(rf_m_rt), .rdata_2_o(rf_s_rs), .rdata_3_o(rf_s_rt)
    );

    forward_unit u_forward_unit (
        .master_rs_i(dec_m.rs), .master_rt_i(dec_m.rt),
        .slave_rs_i(dec_s.rs), .slave_rt_i(dec_s.rt),
        .rf_master_rs_i(rf_m_rs), .rf_master_rt_i(rf_m_rt),
        .rf_slave_rs_i(rf_s_rs), .rf_slave_rt_i(rf_s_rt),
        .e_master_i(e_master_res), .e_slave_i(e_slave_res),
        .m_master_i(m_master_q), .m_slave_i(m_slave_q),
        .master_rs_value_o(op_m_rs), .master_rt_value_o(op_m_rt),
        .slave_rs_value_o(op_s_rs), .slave_rt_value_o(op_s_rt)
    );

    // lane without an issue gets an empty slot
    assign e_master_d = '{valid: pop_count != 2'd0, pc: head0.pc, dec: dec_m,
                          rs_value: op_m_rs, rt_value: op_m_rt};
    assign e_slave_d  = '{valid: pop_count == 2'd2, pc: head1.pc, dec: dec_s,
                          rs_value: op_s_rs, rt_value: op_s_rt};

    lane_alu u_alu_master (.slot_i(e_master_q), .res_o(e_master_res));
    lane_alu u_alu_slave  (.slot_i(e_slave_q),  .res_o(e_slave_res));

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            e_master_q.valid <= 1'b0;
            e_slave_q.valid  <= 1'b0;
            m_master_q.valid <= 1'b0;
            m_slave_q.valid  <= 1'b0;
            w_master_q.valid <= 1'b0;
            w_slave_q.valid  <= 1'b0;
        end else begin
            e_master_q <= e_master_d;
            e_slave_q  <= e_slave_d;
            m_master_q <= e_master_res;
            m_slave_q  <= e_slave_res;
            w_master_q <= m_master_q;
            w_slave_q  <= m_slave_q;
        end
    end

    // only real register writes retire on the ports
    function automatic commit_t to_commit(input result_t r);
        return '{valid: r.valid && r.wen, pc: r.pc, waddr: r.waddr, wdata: r.wdata};
    endfunction

    assign commit_master_o = to_commit(w_master_q);
    assign commit_slave_o  = to_commit(w_slave_q);

    // pairs stay together and in program order from issue down to W
    assert property (@(posedge clk) disable iff (!rst_n_i)
        w_slave_q.valid |-> w_master_q.valid && w_slave_q.pc == w_master_q.pc + `XLEN'd4)
        else $error("dual_issue_core: slave in W without the master just before it");

endmodule

//--- logic/lane_alu.sv
`timescale 1ns/1ps
`include "dual_issue_macros.svh"

module lane_alu import dual_issue_pkg::*; (
    input  exec_slot_t slot_i,
    output result_t    res_o
);

    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] alu_y;

    assign op_a = slot_i.dec.use_shamt ? {{(`XLEN - 5){1'b0}}, slot_i.dec.shamt}
                                       : slot_i.rs_value;
    assign op_b = slot_i.dec.use_imm ? slot_i.dec.imm : slot_i.rt_value;

    always_comb begin
        case (slot_i.dec.alu_op)
            ALU_ADD: alu_y = op_a + op_b;
            ALU_SUB: alu_y = op_a - op_b;
            ALU_AND: alu_y = op_a & op_b;
            ALU_OR:  alu_y = op_a | op_b;
            ALU_XOR: alu_y = op_a ^ op_b;
            ALU_SLT: alu_y = {{(`XLEN - 1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLL: alu_y = op_b << op_a[4:0];
            default: alu_y = '0;
        endcase
    end

    // idle slot never claims a write
    assign res_o.valid = slot_i.valid;
    assign res_o.pc    = slot_i.pc;
    assign res_o.wen   = slot_i.valid && slot_i.dec.wen;
    assign res_o.waddr = slot_i.dec.waddr;
    assign res_o.wdata = alu_y;

endmodule

//--- logic/forward_unit.sv
`timescale 1ns/1ps
`include "dual_issue_macros.svh"

module forward_unit import dual_issue_pkg::*; (
    input  logic [`REG_AW-1:0] master_rs_i,
    input  logic [`REG_AW-1:0] master_rt_i,
    input  logic [`REG_AW-1:0] slave_rs_i,
    input  logic [`REG_AW-1:0] slave_rt_i,
    input  logic [`XLEN-1:0]   rf_master_rs_i,
    input  logic [`XLEN-1:0]   rf_master_rt_i,
    input  logic [`XLEN-1:0]   rf_slave_rs_i,
    input  logic [`XLEN-1:0]   rf_slave_rt_i,
    input  result_t            e_master_i,
    input  result_t            e_slave_i,
    input  result_t            m_master_i,
    input  result_t            m_slave_i,
    output logic [`XLEN-1:0]   master_rs_value_o,
    output logic [`XLEN-1:0]   master_rt_value_o,
    output logic [`XLEN-1:0]   slave_rs_value_o,
    output logic [`XLEN-1:0]   slave_rt_value_o
);

    // youngest producer first, W handled inside the regfile
    function automatic logic [`XLEN-1:0] pick(input logic [`REG_AW-1:0] addr,
                                              input logic [`XLEN-1:0]   rf_data);
        if (e_slave_i.wen && e_slave_i.waddr == addr) begin
            return e_slave_i.wdata;
        end else if (e_master_i.wen && e_master_i.waddr == addr) begin
            return e_master_i.wdata;
        end else if (m_slave_i.wen && m_slave_i.waddr == addr) begin
            return m_slave_i.wdata;
        end else if (m_master_i.wen && m_master_i.waddr == addr) begin
            return m_master_i.wdata;
        end
        return rf_data;
    endfunction

    always_comb begin
        master_rs_value_o = pick(master_rs_i, rf_master_rs_i);
        master_rt_value_o = pick(master_rt_i, rf_master_rt_i);
        slave_rs_value_o  = pick(slave_rs_i, rf_slave_rs_i);
        slave_rt_value_o  = pick(slave_rt_i, rf_slave_rt_i);
    end

endmodule

//--- logic/regfile.sv
`timescale 1ns/1ps
`include "dual_issue_macros.svh"

module regfile import dual_issue_pkg::*; (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic [`REG_AW-1:0] raddr_0_i,
    input  logic [`REG_AW-1:0] raddr_1_i,
    input  logic [`REG_AW-1:0] raddr_2_i,
    input  logic [`REG_AW-1:0] raddr_3_i,
    input  result_t            wr_master_i,
    input  result_t            wr_slave_i,
    output logic [`XLEN-1:0]   rdata_0_o,
    output logic [`XLEN-1:0]   rdata_1_o,
    output logic [`XLEN-1:0]   rdata_2_o,
    output logic [`XLEN-1:0]   rdata_3_o
);

    logic [`XLEN-1:0] regs [2**`REG_AW];
    logic             m_we;
    logic             s_we;

    assign m_we = wr_master_i.valid && wr_master_i.wen;
    assign s_we = wr_slave_i.valid && wr_slave_i.wen;

    // write-through, slave is younger so it wins
    function automatic logic [`XLEN-1:0] read_port(input logic [`REG_AW-1:0] addr);
        if (addr == '0) begin
            return '0;
        end else if (s_we && wr_slave_i.waddr == addr) begin
            return wr_slave_i.wdata;
        end else if (m_we && wr_master_i.waddr == addr) begin
            return wr_master_i.wdata;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rdata_0_o = read_port(raddr_0_i);
        rdata_1_o = read_port(raddr_1_i);
        rdata_2_o = read_port(raddr_2_i);
        rdata_3_o = read_port(raddr_3_i);
    end

    always_ff @(posedge clk) begin
        if (m_we) begin
            regs[wr_master_i.waddr] <= wr_master_i.wdata;
        end
        if (s_we) begin
            regs[wr_slave_i.waddr] <= wr_slave_i.wdata;
        end
    end

    // decoder strips $0 targets long before W
    assert property (@(posedge clk) disable iff (!rst_n_i)
        !(m_we && wr_master_i.waddr == '0) && !(s_we && wr_slave_i.waddr == '0))
        else $error("regfile: write reached register 0");

endmodule

//--- logic/issue_ctrl.sv
`timescale 1ns/1ps
`include "dual_issue_macros.svh"

module issue_ctrl import dual_issue_pkg::*; #(
    parameter int CNT_W = $clog2(`IQ_DEPTH) + 1
) (
    input  logic [CNT_W-1:0] count_i,
    input  decoded_t         master_dec_i,
    input  decoded_t         slave_dec_i,
    output logic [1:0]       pop_count_o
);

    logic raw_hit;
    logic waw_hit;
    logic slave_dep;

    // slave reads or rewrites what the master is producing
    assign raw_hit   = (slave_dec_i.rs == master_dec_i.waddr)
                    || (slave_dec_i.rt == master_dec_i.waddr);
    assign waw_hit   = slave_dec_i.wen && (slave_dec_i.waddr == master_dec_i.waddr);
    assign slave_dep = master_dec_i.wen && (raw_hit || waw_hit);

    always_comb begin
        if (count_i == '0) begin
            pop_count_o = 2'd0;
        end else if (count_i == CNT_W'(1) || slave_dep) begin
            pop_count_o = 2'd1;
        end else begin
            pop_count_o = 2'd2;
        end
    end

endmodule

//--- logic/inst_decoder.sv
`timescale 1ns/1ps
`include "dual_issue_macros.svh"

module inst_decoder import dual_issue_pkg::*; (
    input  logic [`XLEN-1:0] inst_i,
    output decoded_t         dec_o
);

    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [15:0] imm16;
    logic        known;

    assign opcode = inst_i[31:26];
    assign funct  = inst_i[5:0];
    assign imm16  = inst_i[15:0];

    always_comb begin
        known           = 1'b0;
        dec_o.alu_op    = ALU_ADD;
        dec_o.rs        = inst_i[25:21];
        dec_o.rt        = inst_i[20:16];
        dec_o.waddr     = inst_i[15:11];
        dec_o.use_imm   = 1'b0;
        dec_o.use_shamt = 1'b0;
        dec_o.imm       = {{(`XLEN - 16){imm16[15]}}, imm16};
        dec_o.shamt     = inst_i[10:6];
        case (opcode)
            `OP_SPECIAL: begin
                known = 1'b1;
                case (funct)
                    `FN_ADDU: dec_o.alu_op = ALU_ADD;
                    `FN_SUBU: dec_o.alu_op = ALU_SUB;
                    `FN_AND:  dec_o.alu_op = ALU_AND;
                    `FN_OR:   dec_o.alu_op = ALU_OR;
                    `FN_XOR:  dec_o.alu_op = ALU_XOR;
                    `FN_SLT:  dec_o.alu_op = ALU_SLT;
                    `FN_SLL: begin
                        dec_o.alu_op    = ALU_SLL;
                        dec_o.use_shamt = 1'b1;
                    end
                    default:  known = 1'b0;
                endcase
            end
            `OP_ADDIU, `OP_ORI, `OP_LUI: begin
                known         = 1'b1;
                dec_o.waddr   = inst_i[20:16];
                dec_o.use_imm = 1'b1;
                if (opcode == `OP_ORI) begin
                    dec_o.alu_op = ALU_OR;
                    dec_o.imm    = {{(`XLEN - 16){1'b0}}, imm16};
                end else if (opcode == `OP_LUI) begin
                    // immediate shifted up by 16 in the ALU
                    dec_o.alu_op    = ALU_SLL;
                    dec_o.use_shamt = 1'b1;
                    dec_o.shamt     = 5'd16;
                    dec_o.imm       = {{(`XLEN - 16){1'b0}}, imm16};
                end
            end
            default: known = 1'b0;
        endcase
        // $0 target behaves as a nop
        dec_o.wen = known && (dec_o.waddr != '0);
    end

endmodule

//--- logic/fetch_queue.sv
`timescale 1ns/1ps
`include "dual_issue_macros.svh"

module fetch_queue import dual_issue_pkg::*; #(
    parameter int DEPTH = `IQ_DEPTH
) (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  fetch_resp_t              fetch_resp_i,
    input  logic [1:0]               pop_count_i,
    output logic                     fetch_req_o,
    output logic [`XLEN-1:0]         fetch_pc_o,
    output iq_entry_t                head0_o,
    output iq_entry_t                head1_o,
    output logic [$clog2(DEPTH):0]   count_o
);

    localparam int PTR_W = $clog2(DEPTH);

    iq_entry_t        mem [DEPTH];
    logic [PTR_W:0]   rd_ptr_q;
    logic [PTR_W:0]   wr_ptr_q;
    logic [`XLEN-1:0] pc_q;
    logic [PTR_W-1:0] wr_idx0;
    logic [PTR_W-1:0] wr_idx1;
    logic [PTR_W-1:0] rd_idx0;
    logic [PTR_W-1:0] rd_idx1;
    logic             wr_fire;

    // extra pointer bit tells full from empty
    assign count_o    = wr_ptr_q - rd_ptr_q;
    assign fetch_pc_o = pc_q;

    // room for a whole pair or no request at all
    assign fetch_req_o = count_o <= (PTR_W + 1)'(DEPTH - 2);
    assign wr_fire     = fetch_req_o && fetch_resp_i.valid;

    assign wr_idx0 = wr_ptr_q[PTR_W-1:0];
    assign wr_idx1 = wr_idx0 + 1'b1;
    assign rd_idx0 = rd_ptr_q[PTR_W-1:0];
    assign rd_idx1 = rd_idx0 + 1'b1;

    assign head0_o = mem[rd_idx0];
    assign head1_o = mem[rd_idx1];

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            mem[wr_idx0] <= '{pc: pc_q, inst: fetch_resp_i.word0};
            mem[wr_idx1] <= '{pc: pc_q + `XLEN'd4, inst: fetch_resp_i.word1};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_q     <= `RESET_PC;
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (wr_fire) begin
                pc_q     <= pc_q + `XLEN'd8;
                wr_ptr_q <= wr_ptr_q + (PTR_W + 1)'(2);
            end
            rd_ptr_q <= rd_ptr_q + {{(PTR_W - 1){1'b0}}, pop_count_i};
        end
    end

    // issue never takes more than the queue holds
    assert property (@(posedge clk) disable iff (!rst_n_i)
        pop_count_i <= count_o)
        else $error("fetch_queue: pop of %0d with only %0d entries", pop_count_i, count_o);

    // a written pair never overruns the buffer
    assert property (@(posedge clk) disable iff (!rst_n_i)
        wr_fire |=> count_o <= (PTR_W + 1)'(DEPTH))
        else $error("fetch_queue: pair written without two free slots");

endmodule

//--- logic/dual_issue_pkg.sv
`include "dual_issue_macros.svh"

package dual_issue_pkg;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL
    } alu_op_e;

    typedef struct packed {
        logic              valid;
        logic [`XLEN-1:0]  word0;
        logic [`XLEN-1:0]  word1;
    } fetch_resp_t;

    typedef struct packed {
        logic [`XLEN-1:0]  pc;
        logic [`XLEN-1:0]  inst;
    } iq_entry_t;

    // lui arrives here as sll of the zero-extended immediate by 16
    typedef struct packed {
        alu_op_e            alu_op;
        logic [`REG_AW-1:0] rs;
        logic [`REG_AW-1:0] rt;
        logic [`REG_AW-1:0] waddr;
        logic               wen;
        logic               use_imm;
        logic               use_shamt;
        logic [`XLEN-1:0]   imm;
        logic [4:0]         shamt;
    } decoded_t;

    typedef struct packed {
        logic              valid;
        logic [`XLEN-1:0]  pc;
        decoded_t          dec;
        logic [`XLEN-1:0]  rs_value;
        logic [`XLEN-1:0]  rt_value;
    } exec_slot_t;

    typedef struct packed {
        logic               valid;
        logic [`XLEN-1:0]   pc;
        logic               wen;
        logic [`REG_AW-1:0] waddr;
        logic [`XLEN-1:0]   wdata;
    } result_t;

    typedef struct packed {
        logic               valid;
        logic [`XLEN-1:0]   pc;
        logic [`REG_AW-1:0] waddr;
        logic [`XLEN-1:0]   wdata;
    } commit_t;

endpackage

//--- logic/dual_issue_macros.svh
`ifndef DUAL_ISSUE_MACROS_SVH
`define DUAL_ISSUE_MACROS_SVH

`define XLEN        32
`define REG_AW      5
`define RESET_PC    32'hBFC0_0000
`define IQ_DEPTH    8

// major opcodes
`define OP_SPECIAL  6'h00
`define OP_ADDIU    6'h09
`define OP_ORI      6'h0D
`define OP_LUI      6'h0F

// SPECIAL funct field
`define FN_ADDU     6'h21
`define FN_SUBU     6'h23
`define FN_AND      6'h24
`define FN_OR       6'h25
`define FN_XOR      6'h26
`define FN_SLT      6'h2A
`define FN_SLL      6'h00

`endif
